// File: common/dzPkg.sv
`default_nettype none
`include "ucode_defines.svh"

package dzPkg;

	typedef logic [`DZ_DATA_W-1:0] dataT;
	typedef logic [`DZ_ADDR_W-1:0] addrT;
	typedef logic [`DZ_UPC_W-1:0]  uPcT;

	// Flow control field of a micro-op
	typedef enum logic [2:0] {op, inc, eof, incEof, eofNz} uCtrlE;

	// Operation field
	typedef enum logic [2:0] {nop, sma, srm, inc8, dec8, add8, sub8, jrel} uOperE;

	// Operand field, a register or nothing
	typedef enum logic [1:0] {regA, regB, regC, regNone} regSelE;

	typedef enum logic [2:0]
	{
		sFetchReq,
		sFetchWait,
		sFetchDrop,
		sDecode,
		sExec,
		sMemReq,
		sMemWait,
		sMemDrop
	} seqStateE;

endpackage

`default_nettype wire

// File: common/ucode_defines.svh
`ifndef UCODE_DEFINES_SVH
`define UCODE_DEFINES_SVH

// Datapath and program address widths
`define DZ_DATA_W 8
`define DZ_ADDR_W 16

// Micro-op ROM index width
`define DZ_UPC_W 6

// Opcodes run by the core
`define DZ_OP_NOP   8'h00
`define DZ_OP_LDAN  8'h3E
`define DZ_OP_LDBN  8'h06
`define DZ_OP_LDCN  8'h0E
`define DZ_OP_INCA  8'h3C
`define DZ_OP_INCB  8'h04
`define DZ_OP_DECB  8'h05
`define DZ_OP_ADDAB 8'h80
`define DZ_OP_ADDAC 8'h81
`define DZ_OP_SUBB  8'h90
`define DZ_OP_JRN   8'h18
`define DZ_OP_JRNZ  8'h20

`endif

// File: hw/cpuFsm.sv
`timescale 1ns/1ns
`default_nettype none

module cpuFsm
	import dzPkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  memAck,
	output logic  memReq,
	input  uCtrlE uCtrl,
	input  uOperE uOper,
	input  logic  zeroFlag,
	output logic  uPcLoad,
	output logic  uPcInc,
	output logic  pcInc,
	output logic  pcJump,
	output logic  dataLatch,
	output logic  opLatch,
	output logic  execEn
);

	seqStateE state;
	seqStateE nextState;
	logic endFlow;

	////////////////////////////////////////////////////////////////////////////
	// Micro-op decode
	////////////////////////////////////////////////////////////////////////////

	assign endFlow = (uCtrl == eof) || (uCtrl == incEof) || ((uCtrl == eofNz) && zeroFlag);

	assign execEn    = (state == sExec);
	assign uPcLoad   = (state == sDecode);
	assign uPcInc    = execEn && !endFlow;
	assign pcInc     = execEn && ((uCtrl == inc) || (uCtrl == incEof));
	assign pcJump    = execEn && (uOper == jrel);
	assign opLatch   = (state == sFetchWait) && memAck;
	assign dataLatch = (state == sMemWait) && memAck;

	// Request rises after the request state and stays up until ack is seen
	assign memReq = (state == sFetchWait) || (state == sMemWait);

	////////////////////////////////////////////////////////////////////////////
	// Sequencer
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		nextState = state;
		case (state)
			sFetchReq:  nextState = sFetchWait;
			sFetchWait: if (memAck) nextState = sFetchDrop;
			sFetchDrop: if (!memAck) nextState = sDecode;
			sDecode:    nextState = sExec;
			sExec:
			begin
				if (endFlow)
					nextState = sFetchReq;
				else if (uOper == sma)
					nextState = sMemReq;
			end
			sMemReq:    nextState = sMemWait;
			sMemWait:   if (memAck) nextState = sMemDrop;
			// Back to the flow once memory has dropped ack
			sMemDrop:   if (!memAck) nextState = sExec;
			default:    nextState = sFetchReq;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= sFetchReq;
		else
			state <= nextState;
	end

endmodule

`default_nettype wire

// File: hw/dzCpuTop.sv
`timescale 1ns/1ns
`default_nettype none

module dzCpuTop
	import dzPkg::*;
(
	input  logic   clk,
	input  logic   rst,
	output logic   memReq,
	output addrT   memAddr,
	input  logic   memAck,
	input  dataT   memData,
	output logic   regWrValid,
	output regSelE regWrSel,
	output dataT   regWrData,
	output logic   zeroFlag
);

	uPcT flowIdx;
	uPcT uPc;
	uCtrlE uCtrl;
	uOperE uOper;
	regSelE uReg;
	dataT opcode;
	dataT jumpOfs;
	logic uPcLoad;
	logic uPcInc;
	logic pcInc;
	logic pcJump;
	logic dataLatch;
	logic opLatch;
	logic execEn;

	cpuFsm i_fsm (
		.clk(clk), .rst(rst), .memAck(memAck), .memReq(memReq),
		.uCtrl(uCtrl), .uOper(uOper), .zeroFlag(zeroFlag),
		.uPcLoad(uPcLoad), .uPcInc(uPcInc), .pcInc(pcInc), .pcJump(pcJump),
		.dataLatch(dataLatch), .opLatch(opLatch), .execEn(execEn)
	);

	// The program counter is the read address
	seqCounters i_counters (
		.clk(clk), .rst(rst), .flowIdx(flowIdx),
		.uPcLoad(uPcLoad), .uPcInc(uPcInc), .pcInc(pcInc), .pcJump(pcJump),
		.jumpOfs(jumpOfs), .uPc(uPc), .pc(memAddr)
	);

	opcodeMap i_opMap (.opcode(opcode), .flowIdx(flowIdx));

	ucodeRom i_rom (.uPc(uPc), .uCtrl(uCtrl), .uOper(uOper), .uReg(uReg));

	regFileAlu i_regAlu (
		.clk(clk), .rst(rst), .memData(memData),
		.dataLatch(dataLatch), .opLatch(opLatch), .execEn(execEn),
		.uOper(uOper), .uReg(uReg), .opcode(opcode), .jumpOfs(jumpOfs),
		.zeroFlag(zeroFlag), .regWrValid(regWrValid),
		.regWrSel(regWrSel), .regWrData(regWrData)
	);

endmodule

`default_nettype wire

// File: hw/regFileAlu.sv
`timescale 1ns/1ns
`default_nettype none

module regFileAlu
	import dzPkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  dataT   memData,
	input  logic   dataLatch,
	input  logic   opLatch,
	input  logic   execEn,
	input  uOperE  uOper,
	input  regSelE uReg,
	output dataT   opcode,
	output dataT   jumpOfs,
	output logic   zeroFlag,
	output logic   regWrValid,
	output regSelE regWrSel,
	output dataT   regWrData
);

	dataT aReg;
	dataT bReg;
	dataT cReg;
	dataT operand;
	dataT srcVal;
	dataT aluRes;
	regSelE dstSel;
	logic wrEn;
	logic flagEn;

	assign jumpOfs = operand;

	// Read data capture
	always_ff @(posedge clk)
	begin
		if (opLatch)
			opcode <= memData;
		if (dataLatch)
			operand <= memData;
	end

	always_comb
	begin
		case (uReg)
			regA:    srcVal = aReg;
			regB:    srcVal = bReg;
			regC:    srcVal = cReg;
			default: srcVal = '0;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// ALU where ADD and SUB always target A
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		aluRes = operand;
		dstSel = uReg;
		flagEn = 1'b1;
		case (uOper)
			srm:     flagEn = 1'b0;
			inc8:    aluRes = srcVal + 1'b1;
			dec8:    aluRes = srcVal - 1'b1;
			add8:
			begin
				aluRes = aReg + srcVal;
				dstSel = regA;
			end
			sub8:
			begin
				aluRes = aReg - srcVal;
				dstSel = regA;
			end
			default: dstSel = regNone;
		endcase
	end

	assign wrEn = execEn && (dstSel != regNone);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			aReg <= '0;
			bReg <= '0;
			cReg <= '0;
			zeroFlag <= 1'b0;
			regWrValid <= 1'b0;
		end
		else
		begin
			regWrValid <= wrEn;
			if (wrEn)
			begin
				case (dstSel)
					regA:    aReg <= aluRes;
					regB:    bReg <= aluRes;
					regC:    cReg <= aluRes;
					default: ;
				endcase
			end
			// Loads leave Z alone
			if (wrEn && flagEn)
				zeroFlag <= (aluRes == '0);
		end
	end

	// Result port payload
	always_ff @(posedge clk)
	begin
		if (wrEn)
		begin
			regWrSel <= dstSel;
			regWrData <= aluRes;
		end
	end

endmodule

`default_nettype wire

// File: hw/seqCounters.sv
`timescale 1ns/1ns
`default_nettype none
`include "ucode_defines.svh"

module seqCounters
	import dzPkg::*;
(
	input  logic clk,
	input  logic rst,
	input  uPcT  flowIdx,
	input  logic uPcLoad,
	input  logic uPcInc,
	input  logic pcInc,
	input  logic pcJump,
	input  dataT jumpOfs,
	output uPcT  uPc,
	output addrT pc
);

	addrT ofsExt;

	// Signed byte offset widened to the address
	assign ofsExt = {{(`DZ_ADDR_W - `DZ_DATA_W){jumpOfs[`DZ_DATA_W-1]}}, jumpOfs};

	// Micro-program counter
	always_ff @(posedge clk)
	begin
		if (rst)
			uPc <= '0;
		else if (uPcLoad)
			uPc <= flowIdx;
		else if (uPcInc)
			uPc <= uPc + 1'b1;
	end

	// Program counter, a jump is relative to the byte after the operand
	always_ff @(posedge clk)
	begin
		if (rst)
			pc <= '0;
		else if (pcJump)
			pc <= pc + ofsExt;
		else if (pcInc)
			pc <= pc + 1'b1;
	end

endmodule

`default_nettype wire

// File: hw/ucode/opcodeMap.sv
`timescale 1ns/1ns
`default_nettype none
`include "ucode_defines.svh"

module opcodeMap
	import dzPkg::*;
(
	input  dataT opcode,
	output uPcT  flowIdx
);

	// Flow start per opcode, must track the rows in ucodeRom
	always_comb
	begin
		case (opcode)
			`DZ_OP_NOP:   flowIdx = 6'd0;
			`DZ_OP_LDAN:  flowIdx = 6'd1;
			`DZ_OP_LDBN:  flowIdx = 6'd4;
			`DZ_OP_LDCN:  flowIdx = 6'd7;
			`DZ_OP_INCA:  flowIdx = 6'd10;
			`DZ_OP_INCB:  flowIdx = 6'd11;
			`DZ_OP_DECB:  flowIdx = 6'd12;
			`DZ_OP_ADDAB: flowIdx = 6'd13;
			`DZ_OP_ADDAC: flowIdx = 6'd14;
			`DZ_OP_SUBB:  flowIdx = 6'd15;
			`DZ_OP_JRN:   flowIdx = 6'd16;
			`DZ_OP_JRNZ:  flowIdx = 6'd20;
			// Unknown opcodes fall back to the NOP flow
			default:      flowIdx = 6'd0;
		endcase
	end

endmodule

`default_nettype wire

// File: hw/ucode/ucodeRom.sv
`timescale 1ns/1ns
`default_nettype none

module ucodeRom
	import dzPkg::*;
(
	input  uPcT    uPc,
	output uCtrlE  uCtrl,
	output uOperE  uOper,
	output regSelE uReg
);

	localparam int rowW = $bits(uCtrlE) + $bits(uOperE) + $bits(regSelE);

	logic [rowW-1:0] row;

	function automatic logic [rowW-1:0] uRow(input uCtrlE c, input uOperE o, input regSelE r);
		return {c, o, r};
	endfunction

	always_comb
	begin
		case (uPc)
			// NOP
			6'd0:  row = uRow(incEof, nop,  regNone);
			// LD A,n
			6'd1:  row = uRow(inc,    nop,  regNone);
			6'd2:  row = uRow(op,     sma,  regNone);
			6'd3:  row = uRow(incEof, srm,  regA);
			// LD B,n
			6'd4:  row = uRow(inc,    nop,  regNone);
			6'd5:  row = uRow(op,     sma,  regNone);
			6'd6:  row = uRow(incEof, srm,  regB);
			// LD C,n
			6'd7:  row = uRow(inc,    nop,  regNone);
			6'd8:  row = uRow(op,     sma,  regNone);
			6'd9:  row = uRow(incEof, srm,  regC);
			// Single byte ALU ops
			6'd10: row = uRow(incEof, inc8, regA);
			6'd11: row = uRow(incEof, inc8, regB);
			6'd12: row = uRow(incEof, dec8, regB);
			6'd13: row = uRow(incEof, add8, regB);
			6'd14: row = uRow(incEof, add8, regC);
			6'd15: row = uRow(incEof, sub8, regB);
			// JR n
			6'd16: row = uRow(inc,    nop,  regNone);
			6'd17: row = uRow(op,     sma,  regNone);
			6'd18: row = uRow(inc,    nop,  regNone);
			6'd19: row = uRow(eof,    jrel, regNone);
			// JR NZ,n
			6'd20: row = uRow(inc,    nop,  regNone);
			6'd21: row = uRow(op,     sma,  regNone);
			6'd22: row = uRow(inc,    nop,  regNone);
			// pc already past the operand here, so a set Z just stops
			6'd23: row = uRow(eofNz,  nop,  regNone);
			6'd24: row = uRow(eof,    jrel, regNone);
			default:
				row = uRow(op, nop, regNone);
		endcase
	end

	assign uCtrl = uCtrlE'(row[rowW-1 -: $bits(uCtrlE)]);
	assign uOper = uOperE'(row[$bits(regSelE) +: $bits(uOperE)]);
	assign uReg  = regSelE'(row[$bits(regSelE)-1:0]);

endmodule

`default_nettype wire

// File: project.f
+incdir+common
common/dzPkg.sv
hw/ucode/opcodeMap.sv
hw/ucode/ucodeRom.sv
hw/seqCounters.sv
hw/cpuFsm.sv
hw/regFileAlu.sv
hw/dzCpuTop.sv
test/tbClock.sv
test/tbCpu.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -f project.f --top-module tbCpu -o simCpu &&
./obj_dir/simCpu || exit 1

// File: test/tbClock.sv
`timescale 1ns/1ns
`default_nettype none

module tbClock
(
	input  logic rstReq,
	output logic clk,
	output logic rst
);

	// Reset cycles still to go, starts out in reset
	logic [2:0] rstCnt = 3'd4;

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk)
	begin
		if (rstReq)
			rstCnt <= 3'd4;
		else if (rstCnt != 3'd0)
			rstCnt <= rstCnt - 3'd1;
	end

	assign rst = (rstCnt != 3'd0);

endmodule

`default_nettype wire

// File: test/tbCpu.sv
`timescale 1ns/1ns
`default_nettype none

module tbCpu
	import dzPkg::*;
();

	localparam dataT opNop   = 8'h00;
	localparam dataT opLdA   = 8'h3E;
	localparam dataT opLdB   = 8'h06;
	localparam dataT opLdC   = 8'h0E;
	localparam dataT opIncA  = 8'h3C;
	localparam dataT opIncB  = 8'h04;
	localparam dataT opDecB  = 8'h05;
	localparam dataT opAddAB = 8'h80;
	localparam dataT opAddAC = 8'h81;
	localparam dataT opSubB  = 8'h90;
	localparam dataT opJr    = 8'h18;
	localparam dataT opJrNz  = 8'h20;
	localparam int numProgs = 20;
	localparam int eventsPerProg = 200;

	logic clk;
	logic rst;
	logic rstReq = 1'b0;
	logic memReq;
	addrT memAddr;
	logic memAck = 1'b0;
	dataT memData = '0;
	logic regWrValid;
	regSelE regWrSel;
	dataT regWrData;
	logic zeroFlag;

	dataT progMem [0:63];
	int unsigned genSeed = 48091;
	int unsigned delaySeed = 48091;
	logic busy = 1'b0;
	logic [1:0] delayCnt = 2'd0;

	// Reference model state and expected events
	addrT mPc;
	dataT mA;
	dataT mB;
	dataT mC;
	logic mZ;
	addrT expAddrQ [$];
	regSelE expSelQ [$];
	dataT expDataQ [$];
	logic expZQ [$];
	int eventCount = 0;
	logic reqPrev = 1'b0;
	logic rstPrev = 1'b0;

	tbClock i_clock (.rstReq(rstReq), .clk(clk), .rst(rst));

	dzCpuTop i_dut (
		.clk(clk), .rst(rst), .memReq(memReq), .memAddr(memAddr),
		.memAck(memAck), .memData(memData), .regWrValid(regWrValid),
		.regWrSel(regWrSel), .regWrData(regWrData), .zeroFlag(zeroFlag)
	);

	function automatic int lcgNext(inout int unsigned state);
		state = state * 32'd1103515245 + 32'd12345;
		return int'(state[30:16]);
	endfunction

	task automatic failRun(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic checkVal(input logic [15:0] got, input logic [15:0] expVal, input string what);
		if (got !== expVal)
			failRun($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
				$time, what, got, expVal));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Program generator
	////////////////////////////////////////////////////////////////////////////

	// Half of the operands sit near zero so the Z flag gets exercised
	function automatic dataT randOperand();
		int r;
		r = lcgNext(genSeed);
		if (r[9])
			return 8'(r);
		return 8'(r[1:0]) - 8'd1;
	endfunction

	task automatic buildProgram();
		int addr;
		dataT opc;
		addr = 0;
		while (addr <= 52)
		begin
			case (lcgNext(genSeed) % 13)
				0:  opc = opNop;
				1:  opc = opLdA;
				2:  opc = opLdB;
				3:  opc = opLdC;
				4:  opc = opIncA;
				5:  opc = opIncB;
				6:  opc = opDecB;
				7:  opc = opAddAB;
				8:  opc = opAddAC;
				9:  opc = opSubB;
				10: opc = opJr;
				11: opc = opJrNz;
				// Bit 6 set is never a kept opcode
				default: opc = 8'(lcgNext(genSeed)) | 8'h40;
			endcase
			progMem[6'(addr)] = opc;
			addr++;
			if (opc == opLdA || opc == opLdB || opc == opLdC)
			begin
				progMem[6'(addr)] = randOperand();
				addr++;
			end
			else if (opc == opJr || opc == opJrNz)
			begin
				progMem[6'(addr)] = 8'(lcgNext(genSeed) % 4);
				addr++;
			end
		end
		// NOP slide into a closing JR -2 loop
		while (addr < 62)
		begin
			progMem[6'(addr)] = opNop;
			addr++;
		end
		progMem[62] = opJr;
		progMem[63] = 8'hFE;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference interpreter
	////////////////////////////////////////////////////////////////////////////

	function automatic void pushWrite(input regSelE sel, input dataT val);
		expSelQ.push_back(sel);
		expDataQ.push_back(val);
		expZQ.push_back(mZ);
	endfunction

	// Runs one instruction at mPc and queues its reads and register write
	function automatic void refStep();
		dataT opc;
		dataT imm;
		dataT res;
		addrT nextPc;
		opc = progMem[mPc[5:0]];
		imm = progMem[6'(mPc + 16'd1)];
		expAddrQ.push_back(mPc);
		nextPc = mPc + 16'd1;
		if (opc == opLdA || opc == opLdB || opc == opLdC || opc == opJr || opc == opJrNz)
		begin
			expAddrQ.push_back(mPc + 16'd1);
			nextPc = mPc + 16'd2;
		end
		res = '0;
		case (opc)
			opLdA:
			begin
				mA = imm;
				pushWrite(regA, imm);
			end
			opLdB:
			begin
				mB = imm;
				pushWrite(regB, imm);
			end
			opLdC:
			begin
				mC = imm;
				pushWrite(regC, imm);
			end
			opIncA:
			begin
				res = mA + 8'd1;
				mA = res;
			end
			opIncB:
			begin
				res = mB + 8'd1;
				mB = res;
			end
			opDecB:
			begin
				res = mB - 8'd1;
				mB = res;
			end
			opAddAB:
			begin
				res = mA + mB;
				mA = res;
			end
			opAddAC:
			begin
				res = mA + mC;
				mA = res;
			end
			opSubB:
			begin
				res = mA - mB;
				mA = res;
			end
			opJr:
				nextPc = nextPc + {{8{imm[7]}}, imm};
			opJrNz:
			begin
				if (!mZ)
					nextPc = nextPc + {{8{imm[7]}}, imm};
			end
			default: ;
		endcase
		// ALU writes update Z before the write is reported
		if (opc == opIncA || opc == opAddAB || opc == opAddAC || opc == opSubB)
		begin
			mZ = (res == 8'd0);
			pushWrite(regA, res);
		end
		else if (opc == opIncB || opc == opDecB)
		begin
			mZ = (res == 8'd0);
			pushWrite(regB, res);
		end
		mPc = nextPc;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Memory responder for the four phase req/ack with random delay
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk)
	begin
		if (rst)
		begin
			memAck <= 1'b0;
			busy <= 1'b0;
		end
		else if (memAck)
		begin
			if (!memReq)
			begin
				memAck <= 1'b0;
				busy <= 1'b0;
			end
		end
		else if (busy)
		begin
			if (delayCnt == 2'd0)
			begin
				memAck <= 1'b1;
				memData <= progMem[memAddr[5:0]];
			end
			else
				delayCnt <= delayCnt - 2'd1;
		end
		else if (memReq)
		begin
			busy <= 1'b1;
			delayCnt <= 2'(lcgNext(delaySeed) % 4);
		end
	end

	// Comparing process sampling on the falling edge
	always @(negedge clk)
	begin
		addrT expAddr;
		if (rst)
		begin
			if (rstPrev)
			begin
				checkVal(16'(regWrValid), 16'd0, "regWrValid in reset");
				checkVal(16'(memReq), 16'd0, "memReq in reset");
			end
			mPc = '0;
			mA = '0;
			mB = '0;
			mC = '0;
			mZ = 1'b0;
			expAddrQ.delete();
			expSelQ.delete();
			expDataQ.delete();
			expZQ.delete();
			eventCount = 0;
			reqPrev = 1'b0;
		end
		else
		begin
			if (memReq && !reqPrev)
			begin
				if (expAddrQ.size() == 0)
					refStep();
				expAddr = expAddrQ.pop_front();
				checkVal(memAddr, expAddr, "read address");
				eventCount++;
			end
			if (regWrValid)
			begin
				if (expSelQ.size() == 0)
					failRun("The core wrote a register when no write was expected");
				else
				begin
					checkVal(16'(regWrSel), 16'(expSelQ.pop_front()), "write register");
					checkVal(16'(regWrData), 16'(expDataQ.pop_front()), "write data");
					checkVal(16'(zeroFlag), 16'(expZQ.pop_front()), "zero flag");
					eventCount++;
				end
			end
			reqPrev = memReq;
		end
		rstPrev = rst;
	end

	task automatic waitForReset(input logic level);
		int cycles;
		cycles = 0;
		while (rst !== level && cycles < 20)
		begin
			@(posedge clk);
			cycles++;
		end
		if (rst !== level)
			failRun("Timeout waiting for the reset to change");
	endtask

	task automatic waitForEvents(input int target);
		int cycles;
		cycles = 0;
		while (eventCount < target && cycles < 20000)
		begin
			@(posedge clk);
			cycles++;
		end
		if (eventCount < target)
			failRun("Timeout, the core stopped making reads and register writes");
	endtask

	initial
	begin
		int progIdx;
		for (progIdx = 0; progIdx < numProgs; progIdx++)
		begin
			if (progIdx != 0)
			begin
				@(posedge clk);
				rstReq <= 1'b1;
				@(posedge clk);
				rstReq <= 1'b0;
			end
			waitForReset(1'b1);
			buildProgram();
			waitForReset(1'b0);
			waitForEvents(eventsPerProg);
		end
		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire
